//--- verilog/execute_pkg.sv
package execute_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int div_steps = 32;
  localparam int step_count_w = 6;

  typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sub = 4'd1,
    alu_and = 4'd2,
    alu_or = 4'd3,
    alu_xor = 4'd4,
    alu_sll = 4'd5,
    alu_srl = 4'd6,
    alu_sra = 4'd7,
    alu_slt = 4'd8,
    alu_sltu = 4'd9,
    alu_pass_imm = 4'd10  // lui
  } alu_op_t;

  typedef enum logic [1:0] {
    op_div = 2'd0,
    op_divu = 2'd1,
    op_rem = 2'd2,
    op_remu = 2'd3
  } div_op_t;

  typedef enum logic [1:0] {
    seq_idle = 2'd0,
    seq_busy = 2'd1,
    seq_done = 2'd2
  } seq_state_t;

  typedef struct packed {
    logic valid;
    logic [reg_addr_w-1:0] rd;
    alu_op_t alu_op;
    logic use_imm;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
  } basic_instr_t;

  typedef struct packed {
    logic valid;
    logic [reg_addr_w-1:0] rd;
    alu_op_t alu_op;
    logic use_imm;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    logic is_div;
    div_op_t div_op;
  } complex_instr_t;

  typedef struct packed {
    complex_instr_t instr0;
    basic_instr_t instr1;
    logic flush;
    logic hold;
  } execute_in_t;

  typedef struct packed {
    logic valid;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0] wdata;
  } lane_result_t;

  typedef struct packed {
    lane_result_t result0;
    lane_result_t result1;
    logic stall;
  } execute_out_t;

  typedef struct packed {
    logic [xlen-1:0] dividend;
    logic [xlen-1:0] divisor;
    div_op_t div_op;
  } div_in_t;

  localparam execute_out_t init_execute_out = '{
    result0: '{valid: 1'b0, rd: '0, wdata: '0},
    result1: '{valid: 1'b0, rd: '0, wdata: '0},
    stall: 1'b0
  };

endpackage

//--- verilog/int_alu.sv
module int_alu (
  input logic [execute_pkg::xlen-1:0] rdata1,
  input logic [execute_pkg::xlen-1:0] rdata2,
  input logic [execute_pkg::xlen-1:0] imm,
  input logic use_imm,
  input execute_pkg::alu_op_t alu_op,
  output logic [execute_pkg::xlen-1:0] result
);

  logic [execute_pkg::xlen-1:0] op2;
  logic [$clog2(execute_pkg::xlen)-1:0] shamt;
  logic lt_signed;
  logic lt_unsigned;

  always_comb begin
    op2 = use_imm ? imm : rdata2;
    shamt = op2[$clog2(execute_pkg::xlen)-1:0];  // Only low bits count for shifts
    lt_signed = $signed(rdata1) < $signed(op2);
    lt_unsigned = rdata1 < op2;
    case (alu_op)
      execute_pkg::alu_add: result = rdata1 + op2;
      execute_pkg::alu_sub: result = rdata1 - op2;
      execute_pkg::alu_and: result = rdata1 & op2;
      execute_pkg::alu_or: result = rdata1 | op2;
      execute_pkg::alu_xor: result = rdata1 ^ op2;
      execute_pkg::alu_sll: result = rdata1 << shamt;
      execute_pkg::alu_srl: result = rdata1 >> shamt;
      execute_pkg::alu_sra: result = $unsigned($signed(rdata1) >>> shamt);
      execute_pkg::alu_slt: begin
        result = {{(execute_pkg::xlen-1){1'b0}}, lt_signed};
      end
      execute_pkg::alu_sltu: begin
        result = {{(execute_pkg::xlen-1){1'b0}}, lt_unsigned};
      end
      execute_pkg::alu_pass_imm: result = imm;
      default: result = '0;
    endcase
  end

endmodule

//--- verilog/div_step_counter.sv
module div_step_counter (
  input logic clock,
  input logic reset,
  input logic start,
  input logic step,
  output logic last
);

  logic [execute_pkg::step_count_w-1:0] count;

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      count <= '0;
    end else if (start) begin
      count <= execute_pkg::div_steps[execute_pkg::step_count_w-1:0];
    end else if (step && count != '0) begin
      count <= count - 1'b1;  // One per divider iteration
    end
  end

  // Final iteration is the one taken while count is one
  assign last = (count == 1);

endmodule

//--- verilog/serial_divider.sv
module serial_divider (
  input logic clock,
  input logic reset,
  input execute_pkg::div_in_t div_in,
  input logic start,
  input logic step,
  output logic [execute_pkg::xlen-1:0] result
);

  execute_pkg::div_op_t op;
  logic neg_quo;
  logic neg_rem;
  logic by_zero;
  logic is_signed;
  logic neg_a;
  logic neg_b;
  logic [execute_pkg::xlen-1:0] dividend_mag;
  logic [execute_pkg::xlen-1:0] divisor_in_mag;
  logic [execute_pkg::xlen-1:0] divisor_mag;
  logic [execute_pkg::xlen-1:0] quo;
  logic [execute_pkg::xlen-1:0] rem;
  logic [execute_pkg::xlen:0] shifted;
  logic [execute_pkg::xlen:0] diff;
  logic [execute_pkg::xlen-1:0] quotient;
  logic [execute_pkg::xlen-1:0] remainder;

  always_comb begin
    is_signed = (div_in.div_op == execute_pkg::op_div) || (div_in.div_op == execute_pkg::op_rem);
    neg_a = is_signed & div_in.dividend[execute_pkg::xlen-1];
    neg_b = is_signed & div_in.divisor[execute_pkg::xlen-1];
    dividend_mag = neg_a ? -div_in.dividend : div_in.dividend;
    divisor_in_mag = neg_b ? -div_in.divisor : div_in.divisor;
  end

  // Partial remainder with the next dividend bit shifted in
  assign shifted = {rem, quo[execute_pkg::xlen-1]};
  assign diff = shifted - {1'b0, divisor_mag};

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      op <= execute_pkg::op_divu;
      neg_quo <= 1'b0;
      neg_rem <= 1'b0;
      by_zero <= 1'b0;
    end else if (start) begin
      op <= div_in.div_op;
      neg_quo <= neg_a ^ neg_b;
      neg_rem <= neg_a;  // Remainder takes the dividend sign
      by_zero <= (div_in.divisor == '0);
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      divisor_mag <= divisor_in_mag;
      quo <= dividend_mag;
      rem <= '0;
    end else if (step) begin
      if (diff[execute_pkg::xlen] == 1'b0) begin
        rem <= diff[execute_pkg::xlen-1:0];
        quo <= {quo[execute_pkg::xlen-2:0], 1'b1};
      end else begin
        rem <= shifted[execute_pkg::xlen-1:0];  // Restore
        quo <= {quo[execute_pkg::xlen-2:0], 1'b0};
      end
    end
  end

  // Overflow case falls out of the magnitude math, only divide by zero needs a fixup
  always_comb begin
    quotient = neg_quo ? -quo : quo;
    if (by_zero) begin
      quotient = '1;
    end
    remainder = neg_rem ? -rem : rem;
    if (op == execute_pkg::op_div || op == execute_pkg::op_divu) begin
      result = quotient;
    end else begin
      result = remainder;
    end
  end

endmodule

//--- verilog/div_sequencer.sv
module div_sequencer (
  input logic clock,
  input logic reset,
  input logic request,
  input logic hold,
  input logic flush,
  input logic last,
  output logic start,
  output logic step,
  output logic stall,
  output execute_pkg::seq_state_t state
);

  execute_pkg::seq_state_t next_state;

  always_comb begin
    next_state = state;
    start = 1'b0;
    step = 1'b0;
    stall = 1'b0;
    case (state)
      execute_pkg::seq_idle: begin
        if (request) begin
          stall = 1'b1;  // Raised in the request cycle itself
          if (!hold) begin
            start = 1'b1;
            next_state = execute_pkg::seq_busy;
          end
        end
      end
      execute_pkg::seq_busy: begin
        stall = 1'b1;
        if (!hold) begin
          step = 1'b1;
          if (last) begin
            next_state = execute_pkg::seq_done;
          end
        end
      end
      execute_pkg::seq_done: begin
        if (!hold) begin
          next_state = execute_pkg::seq_idle;  // Result leaves through y this cycle
        end
      end
      default: next_state = execute_pkg::seq_idle;
    endcase
    if (flush) begin
      next_state = execute_pkg::seq_idle;  // Abort, wins over hold
      start = 1'b0;
      step = 1'b0;
      stall = 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      state <= execute_pkg::seq_idle;
    end else begin
      state <= next_state;
    end
  end

endmodule

//--- verilog/execute_stage.sv
module execute_stage (
  input logic clock,
  input logic reset,
  input execute_pkg::execute_in_t d,
  output execute_pkg::execute_out_t y,
  output execute_pkg::execute_out_t q
);

  logic [execute_pkg::xlen-1:0] alu0_result;
  logic [execute_pkg::xlen-1:0] alu1_result;
  logic [execute_pkg::xlen-1:0] div_result;
  execute_pkg::div_in_t div_in;
  logic div_request;
  logic div_start;
  logic div_step;
  logic div_stall;
  logic div_last;
  logic div_ready;
  execute_pkg::seq_state_t div_state;
  execute_pkg::execute_out_t r;

  int_alu u_alu0 (
    .rdata1(d.instr0.rdata1),
    .rdata2(d.instr0.rdata2),
    .imm(d.instr0.imm),
    .use_imm(d.instr0.use_imm),
    .alu_op(d.instr0.alu_op),
    .result(alu0_result)
  );

  int_alu u_alu1 (
    .rdata1(d.instr1.rdata1),
    .rdata2(d.instr1.rdata2),
    .imm(d.instr1.imm),
    .use_imm(d.instr1.use_imm),
    .alu_op(d.instr1.alu_op),
    .result(alu1_result)
  );

  assign div_in.dividend = d.instr0.rdata1;
  assign div_in.divisor = d.instr0.rdata2;
  assign div_in.div_op = d.instr0.div_op;
  assign div_request = d.instr0.valid & d.instr0.is_div;

  serial_divider u_serial_divider (
    .clock(clock),
    .reset(reset),
    .div_in(div_in),
    .start(div_start),
    .step(div_step),
    .result(div_result)
  );

  div_step_counter u_div_step_counter (
    .clock(clock),
    .reset(reset),
    .start(div_start),
    .step(div_step),
    .last(div_last)
  );

  div_sequencer u_div_sequencer (
    .clock(clock),
    .reset(reset),
    .request(div_request),
    .hold(d.hold),
    .flush(d.flush),
    .last(div_last),
    .start(div_start),
    .step(div_step),
    .stall(div_stall),
    .state(div_state)
  );

  assign div_ready = (div_state == execute_pkg::seq_done);

  always_comb begin
    y.result0.valid = d.instr0.valid & (~d.instr0.is_div | div_ready);
    y.result0.rd = d.instr0.rd;
    y.result0.wdata = d.instr0.is_div ? div_result : alu0_result;
    y.result1.valid = d.instr1.valid;
    y.result1.rd = d.instr1.rd;
    y.result1.wdata = alu1_result;
    y.stall = div_stall;
    if (div_stall || d.flush) begin
      y.result0.valid = 1'b0;  // Bubble both lanes
      y.result1.valid = 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      r <= execute_pkg::init_execute_out;
    end else if (d.flush || !d.hold) begin
      r <= y;
    end
  end

  assign q = r;

endmodule

//--- tests/execute_checker.sv
module execute_checker (
  input logic clock,
  input logic reset,
  input logic flush,
  input logic hold,
  input logic last,
  input logic stall,
  input execute_pkg::seq_state_t state,
  input execute_pkg::execute_out_t q
);

  timeunit 1ns;
  timeprecision 1ps;

  // Stall drops into done only after the counter's last step
  stall_ends_after_last: assert property (@(posedge clock) disable iff (reset == 0)
    ($fell(stall) && !flush) |-> (state == execute_pkg::seq_done && $past(last)))
    else $error("stall fell before the last divide step");

  flush_bubbles: assert property (@(posedge clock) disable iff (reset == 0)
    flush |=> (!q.result0.valid && !q.result1.valid))
    else $error("valid lane in q in the cycle after a flush");

  hold_keeps_q: assert property (@(posedge clock) disable iff (reset == 0)
    (hold && !flush) |=> $stable(q))
    else $error("q changed while hold was high");

endmodule

bind execute_stage execute_checker u_execute_checker (
  .clock(clock),
  .reset(reset),
  .flush(d.flush),
  .hold(d.hold),
  .last(div_last),
  .stall(y.stall),
  .state(div_state),
  .q(q)
);

//--- tests/execute_monitor.sv
module execute_monitor (
  input logic clock,
  input execute_pkg::execute_out_t y,
  input execute_pkg::execute_out_t q,
  input logic [127:0] name,
  input execute_pkg::lane_result_t exp0,
  input execute_pkg::lane_result_t exp1,
  input logic is_flush,
  input logic is_hold,
  input logic is_div,
  input logic go,
  output logic done,
  output int pass_count,
  output int fail_count
);

  timeunit 1ns;
  timeprecision 1ps;

  task automatic check_test();
    int errs;
    int cycles;
    int stall_cycles;
    logic stall_seen;
    logic q_stall_seen;
    logic valid_seen;
    execute_pkg::execute_out_t first;
    errs = 0;
    cycles = 0;
    stall_cycles = 0;
    stall_seen = 1'b0;
    q_stall_seen = 1'b0;
    valid_seen = 1'b0;
    if (is_flush) begin
      repeat (40) begin  // Longer than a full division
        @(negedge clock);
        if (y.stall) stall_cycles++;
        if ((q.result0.valid || q.result1.valid) && !valid_seen) begin
          $display("%0s: a valid result reached q although the division was flushed", name);
          valid_seen = 1'b1;
          errs++;
        end
      end
      if (stall_cycles == 0) begin
        $display("%0s: stall never rose for the flushed division", name);
        errs++;
      end else if (stall_cycles > execute_pkg::div_steps) begin
        $display("%0s: stall lasted a whole division so the flush did not abort it", name);
        errs++;
      end
    end else begin
      @(negedge clock);
      while (!(q.result0.valid || q.result1.valid) && cycles < 60) begin
        if (y.stall) stall_seen = 1'b1;
        if (q.stall) q_stall_seen = 1'b1;
        @(negedge clock);
        cycles++;
      end
      if (!(q.result0.valid || q.result1.valid)) begin
        $display("%0s: no valid result appeared in q", name);
        errs++;
      end else begin
        if (q.result0 !== exp0) begin
          $display("ERR %0s lane0 expected %h actual %h", name, exp0, q.result0);
          errs++;
        end
        if (q.result1 !== exp1) begin
          $display("ERR %0s lane1 expected %h actual %h", name, exp1, q.result1);
          errs++;
        end
        if (is_div && !stall_seen) begin
          $display("%0s: stall never rose during the division", name);
          errs++;
        end
        if (is_div && !q_stall_seen) begin
          $display("%0s: stall never showed in q during the division", name);
          errs++;
        end
        if (!is_div && stall_seen) begin
          $display("%0s: stall rose for a pair without a division", name);
          errs++;
        end
        if (is_hold) begin
          first = q;
          repeat (3) begin
            @(negedge clock);
            if (q !== first) begin
              $display("ERR %0s held q expected %h actual %h", name, first, q);
              errs++;
            end
          end
        end
      end
    end
    if (errs == 0) begin
      $display("%0s: ok", name);
      pass_count++;
    end else begin
      $display("%0s: bad, %0d errors", name, errs);
      fail_count++;
    end
  endtask

  initial begin
    done = 1'b0;
    pass_count = 0;
    fail_count = 0;
    forever begin
      wait (go);
      check_test();
      done = 1'b1;
      wait (!go);
      done = 1'b0;
    end
  end

endmodule

//--- tests/execute_tb.sv
module execute_tb;

  timeunit 1ns;
  timeprecision 1ps;

  logic clock;
  logic reset;
  execute_pkg::execute_in_t d;
  execute_pkg::execute_out_t y;
  execute_pkg::execute_out_t q;

  execute_pkg::execute_in_t stim[$];
  execute_pkg::lane_result_t exp0_q[$];
  execute_pkg::lane_result_t exp1_q[$];
  logic [127:0] names[$];
  int n_tests;
  logic loaded;
  logic load_failed;

  logic [127:0] cur_name;
  execute_pkg::lane_result_t cur_exp0;
  execute_pkg::lane_result_t cur_exp1;
  logic cur_flush;
  logic cur_hold;
  logic cur_div;
  logic go;
  logic done;
  int pass_count;
  int fail_count;

  execute_stage u_execute_stage (.clock(clock), .reset(reset), .d(d), .y(y), .q(q));

  execute_monitor u_execute_monitor (
    .clock(clock), .y(y), .q(q), .name(cur_name), .exp0(cur_exp0), .exp1(cur_exp1),
    .is_flush(cur_flush), .is_hold(cur_hold), .is_div(cur_div), .go(go), .done(done),
    .pass_count(pass_count), .fail_count(fail_count)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic load_tests();
    int fd;
    int code;
    logic [127:0] tok;
    string line;
    logic [31:0] f [24];
    execute_pkg::execute_in_t s;
    fd = $fopen("tests/execute_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open tests/execute_tests.txt");
      $display("test failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) break;
        if (tok == 128'h23) begin  // Comment line
          code = $fgets(line, fd);
          continue;
        end
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
          f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22], f[23]);
        if (code != 24) begin
          $display("malformed entry in the test file after %0s", tok);
          load_failed = 1'b1;
          break;
        end
        s = '0;
        s.instr0.valid = f[0][0];
        s.instr0.rd = f[1][4:0];
        s.instr0.alu_op = execute_pkg::alu_op_t'(f[2][3:0]);
        s.instr0.use_imm = f[3][0];
        s.instr0.imm = f[4];
        s.instr0.rdata1 = f[5];
        s.instr0.rdata2 = f[6];
        s.instr0.is_div = f[7][0];
        s.instr0.div_op = execute_pkg::div_op_t'(f[8][1:0]);
        s.instr1.valid = f[9][0];
        s.instr1.rd = f[10][4:0];
        s.instr1.alu_op = execute_pkg::alu_op_t'(f[11][3:0]);
        s.instr1.use_imm = f[12][0];
        s.instr1.imm = f[13];
        s.instr1.rdata1 = f[14];
        s.instr1.rdata2 = f[15];
        s.flush = f[16][0];  // Marks a flush test and is raised later on its own
        s.hold = f[17][0];
        stim.push_back(s);
        exp0_q.push_back('{valid: f[18][0], rd: f[19][4:0], wdata: f[20]});
        exp1_q.push_back('{valid: f[21][0], rd: f[22][4:0], wdata: f[23]});
        names.push_back(tok);
      end
      $fclose(fd);
    end
  endtask

  task automatic run_test(input int i);
    execute_pkg::execute_in_t s;
    s = stim[i];
    cur_name = names[i];
    cur_exp0 = exp0_q[i];
    cur_exp1 = exp1_q[i];
    cur_flush = s.flush;
    cur_hold = s.hold;
    cur_div = s.instr0.valid & s.instr0.is_div;
    s.flush = 1'b0;
    s.hold = 1'b0;
    @(posedge clock);
    d <= s;
    go = 1'b1;
    if (cur_flush) begin
      repeat (5) @(posedge clock);
      d <= '{instr0: '0, instr1: '0, flush: 1'b1, hold: 1'b0};
      @(posedge clock);
      d <= '0;
    end else begin
      @(negedge clock);
      while (y.stall) @(negedge clock);
      @(posedge clock);  // Pair accepted here
      d <= '{instr0: '0, instr1: '0, flush: 1'b0, hold: cur_hold};
      if (cur_hold) begin
        repeat (3) @(posedge clock);
        d <= '0;
      end
    end
    wait (done);
    go = 1'b0;
    wait (!done);
  endtask

  initial begin
    loaded = 1'b0;
    wait (loaded);
    repeat (n_tests * 50) @(posedge clock);
    $display("timeout: tests did not finish within %0d cycles", n_tests * 50);
    $display("test failed");
    $finish;
  end

  initial begin
    reset = 1'b0;
    d = '0;
    go = 1'b0;
    load_failed = 1'b0;
    cur_name = '0;
    cur_exp0 = '0;
    cur_exp1 = '0;
    cur_flush = 1'b0;
    cur_hold = 1'b0;
    cur_div = 1'b0;
    load_tests();
    n_tests = stim.size();
    loaded = 1'b1;
    repeat (4) @(posedge clock);
    reset <= 1'b1;
    for (int i = 0; i < n_tests; i++) begin
      run_test(i);
    end
    repeat (2) @(posedge clock);
    $display("%0d tests: %0d ok, %0d bad", n_tests, pass_count, fail_count);
    if (!load_failed && fail_count == 0 && pass_count == n_tests && n_tests > 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- src.f
verilog/execute_pkg.sv
verilog/int_alu.sv
verilog/div_step_counter.sv
verilog/serial_divider.sv
verilog/div_sequencer.sv
verilog/execute_stage.sv
tests/execute_checker.sv
tests/execute_monitor.sv
tests/execute_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module execute_tb \
  --Mdir obj_dir -o execute_sim \
  && { ./obj_dir/execute_sim > sim.log 2>&1 || true; } \
  && cat sim.log \
  && grep -qx "test passed" sim.log \
  || exit 1
exit 0

//--- tests/execute_tests.txt
# name v0 rd0 op0 sel0 imm0 a0 b0 is_div div_op v1 rd1 op1 sel1 imm1 a1 b1 flush hold
# next line: expected v0 rd0 wdata0 v1 rd1 wdata1 (all hex)
add_sub    1 01 0 0 00000000 00000005 00000007 0 0  1 02 1 0 00000000 0000000a 00000003 0 0
  1 01 0000000c  1 02 00000007
sra_sltu   1 03 7 1 00000004 f0000000 00000000 0 0  1 04 9 0 00000000 ffffffff 00000001 0 0
  1 03 ff000000  1 04 00000000
xor_slt    1 05 4 0 00000000 0f0f0f0f 00ff00ff 0 0  1 06 8 0 00000000 ffffffff 00000001 0 0
  1 05 0ff00ff0  1 06 00000001
lui_sll    1 07 a 1 12345000 00000000 00000000 0 0  1 08 5 1 0000001f 00000001 00000000 0 0
  1 07 12345000  1 08 80000000
srl_or     1 09 6 0 00000000 80000000 0000001f 0 0  1 0a 3 0 00000000 0000f000 0000000f 0 0
  1 09 00000001  1 0a 0000f00f
div_signed 1 0b 0 0 00000000 ffffff9c 00000007 1 0  0 00 0 0 00000000 00000000 00000000 0 0
  1 0b fffffff2  0 00 00000000
rem_signed 1 0c 0 0 00000000 ffffff9c 00000007 1 2  0 00 0 0 00000000 00000000 00000000 0 0
  1 0c fffffffe  0 00 00000000
divu_big   1 0d 0 0 00000000 ffffff9c 00000007 1 1  0 00 0 0 00000000 00000000 00000000 0 0
  1 0d 24924916  0 00 00000000
remu_big   1 0e 0 0 00000000 ffffff9c 00000007 1 3  0 00 0 0 00000000 00000000 00000000 0 0
  1 0e 00000002  0 00 00000000
div_zero   1 0f 0 0 00000000 00001234 00000000 1 0  0 00 0 0 00000000 00000000 00000000 0 0
  1 0f ffffffff  0 00 00000000
rem_zero   1 10 0 0 00000000 00001234 00000000 1 2  0 00 0 0 00000000 00000000 00000000 0 0
  1 10 00001234  0 00 00000000
div_ovf    1 11 0 0 00000000 80000000 ffffffff 1 0  0 00 0 0 00000000 00000000 00000000 0 0
  1 11 80000000  0 00 00000000
rem_ovf    1 12 0 0 00000000 80000000 ffffffff 1 2  0 00 0 0 00000000 00000000 00000000 0 0
  1 12 00000000  0 00 00000000
flush_div  1 13 0 0 00000000 00000064 00000003 1 0  0 00 0 0 00000000 00000000 00000000 1 0
  0 00 00000000  0 00 00000000
after_flush 1 13 0 0 00000000 00000003 00000004 0 0  1 14 0 1 00000020 00000010 00000000 0 0
  1 13 00000007  1 14 00000030
hold_alu   1 15 1 0 00000000 00000005 00000008 0 0  0 00 0 0 00000000 00000000 00000000 0 1
  1 15 fffffffd  0 00 00000000
div_pair   1 16 0 0 00000000 00000064 00000005 1 1  1 17 0 0 00000000 00000001 00000001 0 0
  1 16 00000014  1 17 00000002
